/* rtl/conv_pkg.sv */
package conv_pkg;

    // layer geometry
    localparam int IFM_SIZE    = 6;
    localparam int KERNEL_SIZE = 3;
    localparam int OFM_SIZE    = IFM_SIZE - KERNEL_SIZE + 1;
    localparam int IFM_DEPTH   = 2;
    localparam int NUM_FILTERS = 2;
    localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;

    localparam int DATA_WIDTH = 16;
    localparam int ACC_WIDTH  = 36;

    // weights first in filter, depth, tap order; biases after them.
    localparam int BIAS_BASE      = NUM_FILTERS * IFM_DEPTH * KERNEL_TAPS;
    localparam int IFM_ADDR_WIDTH = $clog2(IFM_DEPTH * IFM_SIZE * IFM_SIZE);
    localparam int WT_ADDR_WIDTH  = $clog2(BIAS_BASE + NUM_FILTERS);
    localparam int OFM_ADDR_WIDTH = $clog2(NUM_FILTERS * OFM_SIZE * OFM_SIZE);

    localparam int FILTER_IDX_WIDTH = $clog2(NUM_FILTERS);
    localparam int DEPTH_IDX_WIDTH  = $clog2(IFM_DEPTH);

    localparam int LINE_DEPTH   = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;
    localparam int DRAIN_CYCLES = 3; // pixel, window and product stages.

    localparam logic signed [ACC_WIDTH-1:0] OUT_MAX = (1 <<< (DATA_WIDTH - 1)) - 1;

    typedef enum logic [2:0] {IDLE, LOAD, STREAM, DRAIN, HOLD} ctrl_state_t;

    typedef enum logic [1:0] {FETCH_IDLE, FETCH_TAPS, FETCH_BIAS} fetch_state_t;

endpackage

/* rtl/conv_control.sv */
`timescale 1ns/100ps

module conv_control
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  start,
    input  logic                                  kernel_ready,
    input  logic                                  plane_done,
    input  logic                                  plane_ack,
    output logic                                  ready,
    output logic                                  done,
    output logic                                  plane_full,
    output logic                                  ifm_rd,
    output logic [conv_pkg::IFM_ADDR_WIDTH-1:0]   ifm_addr,
    output logic                                  pix_valid,
    output logic                                  load_go,
    output logic [conv_pkg::FILTER_IDX_WIDTH-1:0] filter_idx,
    output logic [conv_pkg::DEPTH_IDX_WIDTH-1:0]  depth_idx,
    output logic                                  first_depth,
    output logic                                  last_depth
);
    import conv_pkg::*;

    ctrl_state_t                          state;
    logic [$clog2(IFM_SIZE*IFM_SIZE)-1:0] pix_cnt;
    logic [$clog2(DRAIN_CYCLES)-1:0]      drain_cnt;
    logic                                 last_filter;

    assign ready       = (state == IDLE);
    assign first_depth = (depth_idx == '0);
    assign last_depth  = (depth_idx == DEPTH_IDX_WIDTH'(IFM_DEPTH - 1));
    assign last_filter = (filter_idx == FILTER_IDX_WIDTH'(NUM_FILTERS - 1));
    assign ifm_addr    = IFM_ADDR_WIDTH'(depth_idx * (IFM_SIZE * IFM_SIZE) + pix_cnt);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= IDLE;
            filter_idx <= '0;
            depth_idx  <= '0;
            pix_cnt    <= '0;
            drain_cnt  <= '0;
            ifm_rd     <= 1'b0;
            load_go    <= 1'b0;
            done       <= 1'b0;
        end
        else
        begin
            load_go <= 1'b0;
            done    <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        filter_idx <= '0;
                        depth_idx  <= '0;
                        load_go    <= 1'b1;
                        state      <= LOAD;
                    end
                end
                LOAD:
                begin
                    if (kernel_ready)
                    begin
                        pix_cnt <= '0;
                        ifm_rd  <= 1'b1; // raster read starts with the kernel in place.
                        state   <= STREAM;
                    end
                end
                STREAM:
                begin
                    if (pix_cnt == IFM_SIZE * IFM_SIZE - 1)
                    begin
                        ifm_rd    <= 1'b0;
                        drain_cnt <= '0;
                        state     <= DRAIN;
                    end
                    else
                        pix_cnt <= pix_cnt + 1'b1;
                end
                DRAIN:
                begin
                    if (drain_cnt == DRAIN_CYCLES - 1)
                    begin
                        if (last_depth)
                            state <= HOLD;
                        else
                        begin
                            depth_idx <= depth_idx + 1'b1;
                            load_go   <= 1'b1;
                            state     <= LOAD;
                        end
                    end
                    else
                        drain_cnt <= drain_cnt + 1'b1;
                end
                HOLD:
                begin
                    // next layer has taken the plane.
                    if (plane_full && plane_ack)
                    begin
                        depth_idx <= '0;
                        if (last_filter)
                        begin
                            filter_idx <= '0;
                            done       <= 1'b1;
                            state      <= IDLE;
                        end
                        else
                        begin
                            filter_idx <= filter_idx + 1'b1;
                            load_go    <= 1'b1;
                            state      <= LOAD;
                        end
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // read data comes back one cycle after the strobe.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pix_valid <= 1'b0;
        else
            pix_valid <= ifm_rd;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            plane_full <= 1'b0;
        else if (plane_full && plane_ack)
            plane_full <= 1'b0;
        else if (plane_done)
            plane_full <= 1'b1;
    end

    assert property (@(posedge clk) disable iff (reset) ifm_rd |-> state == STREAM);
    assert property (@(posedge clk) disable iff (reset) plane_full |-> state == HOLD);

endmodule

/* rtl/window_shifter.sv */
`timescale 1ns/100ps

module window_shifter
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   pix_valid,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] ifm_data,
    output logic signed [conv_pkg::DATA_WIDTH-1:0] window [conv_pkg::KERNEL_TAPS],
    output logic                                   window_valid
);
    import conv_pkg::*;

    logic signed [DATA_WIDTH-1:0] line_buf [LINE_DEPTH];
    logic [$clog2(IFM_SIZE)-1:0]  col_cnt;
    logic [$clog2(IFM_SIZE)-1:0]  row_cnt;

    always_ff @(posedge clk)
    begin
        if (pix_valid)
        begin
            line_buf[0] <= ifm_data;
            for (int i = 1; i < LINE_DEPTH; i++)
                line_buf[i] <= line_buf[i-1];
        end
    end

    // tap 0 is the oldest pixel, top left of the window.
    always_comb
    begin
        for (int kr = 0; kr < KERNEL_SIZE; kr++)
        begin
            for (int kc = 0; kc < KERNEL_SIZE; kc++)
                window[kr*KERNEL_SIZE + kc] =
                    line_buf[(KERNEL_SIZE-1-kr)*IFM_SIZE + (KERNEL_SIZE-1-kc)];
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            col_cnt      <= '0;
            row_cnt      <= '0;
            window_valid <= 1'b0;
        end
        else
        begin
            // full window once the pixel sits at row and column >= 2.
            window_valid <= pix_valid && (col_cnt >= KERNEL_SIZE - 1)
                                      && (row_cnt >= KERNEL_SIZE - 1);
            if (pix_valid)
            begin
                if (col_cnt == IFM_SIZE - 1)
                begin
                    col_cnt <= '0;
                    row_cnt <= (row_cnt == IFM_SIZE - 1) ? '0 : row_cnt + 1'b1;
                end
                else
                    col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        row_cnt * IFM_SIZE + col_cnt <= IFM_SIZE * IFM_SIZE - 1);

endmodule

/* rtl/weight_fetch.sv */
`timescale 1ns/100ps

module weight_fetch
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   load_go,
    input  logic [conv_pkg::FILTER_IDX_WIDTH-1:0]  filter_idx,
    input  logic [conv_pkg::DEPTH_IDX_WIDTH-1:0]   depth_idx,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] wt_data,
    output logic                                   wt_rd,
    output logic [conv_pkg::WT_ADDR_WIDTH-1:0]     wt_addr,
    output logic signed [conv_pkg::DATA_WIDTH-1:0] kernel [conv_pkg::KERNEL_TAPS],
    output logic signed [conv_pkg::DATA_WIDTH-1:0] bias,
    output logic                                   kernel_ready
);
    import conv_pkg::*;

    fetch_state_t                     state;
    logic [$clog2(KERNEL_TAPS+1)-1:0] tap_cnt;
    logic [$clog2(KERNEL_TAPS+1)-1:0] rd_idx;
    logic                             rd_valid;
    logic [WT_ADDR_WIDTH-1:0]         tap_base;

    assign tap_base = WT_ADDR_WIDTH'((filter_idx * IFM_DEPTH + depth_idx) * KERNEL_TAPS);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state        <= FETCH_IDLE;
            wt_rd        <= 1'b0;
            wt_addr      <= '0;
            tap_cnt      <= '0;
            rd_valid     <= 1'b0;
            kernel_ready <= 1'b0;
        end
        else
        begin
            rd_valid     <= wt_rd;
            kernel_ready <= (state == FETCH_BIAS); // bias data lands this cycle.
            case (state)
                FETCH_IDLE:
                begin
                    if (load_go)
                    begin
                        wt_rd   <= 1'b1;
                        wt_addr <= tap_base;
                        tap_cnt <= '0;
                        state   <= FETCH_TAPS;
                    end
                end
                FETCH_TAPS:
                begin
                    if (tap_cnt == KERNEL_TAPS - 1)
                    begin
                        wt_addr <= WT_ADDR_WIDTH'(BIAS_BASE + filter_idx);
                        state   <= FETCH_BIAS;
                    end
                    else
                        wt_addr <= wt_addr + 1'b1;
                    tap_cnt <= tap_cnt + 1'b1;
                end
                FETCH_BIAS:
                begin
                    wt_rd <= 1'b0;
                    state <= FETCH_IDLE;
                end
                default:
                    state <= FETCH_IDLE;
            endcase
        end
    end

    // index 9 is the bias word.
    always_ff @(posedge clk)
    begin
        rd_idx <= tap_cnt;
        if (rd_valid)
        begin
            if (rd_idx == KERNEL_TAPS)
                bias <= wt_data;
            else
                kernel[rd_idx] <= wt_data;
        end
    end

endmodule

/* rtl/mac_accumulate.sv */
`timescale 1ns/100ps

module mac_accumulate
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] window [conv_pkg::KERNEL_TAPS],
    input  logic                                   window_valid,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] kernel [conv_pkg::KERNEL_TAPS],
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] bias,
    input  logic                                   first_depth,
    input  logic                                   last_depth,
    input  logic [conv_pkg::FILTER_IDX_WIDTH-1:0]  filter_idx,
    output logic                                   ofm_we,
    output logic [conv_pkg::OFM_ADDR_WIDTH-1:0]    ofm_addr,
    output logic signed [conv_pkg::DATA_WIDTH-1:0] ofm_data,
    output logic                                   plane_done
);
    import conv_pkg::*;

    logic signed [ACC_WIDTH-1:0]          dot;
    logic signed [ACC_WIDTH-1:0]          dot_q;
    logic                                 dot_valid;
    logic signed [ACC_WIDTH-1:0]          psum_buf [OFM_SIZE*OFM_SIZE];
    logic [$clog2(OFM_SIZE*OFM_SIZE)-1:0] pos_cnt;
    logic signed [ACC_WIDTH-1:0]          psum_total;
    logic signed [ACC_WIDTH-1:0]          bias_ext;
    logic signed [ACC_WIDTH-1:0]          biased;
    logic signed [DATA_WIDTH-1:0]         relu_out;

    always_comb
    begin
        dot = '0;
        for (int i = 0; i < KERNEL_TAPS; i++)
            dot = dot + window[i] * kernel[i];
    end

    assign bias_ext   = bias; // sign extended.
    assign psum_total = first_depth ? dot_q : psum_buf[pos_cnt] + dot_q;
    assign biased     = psum_total + bias_ext;

    // relu, then saturate to the output word.
    always_comb
    begin
        if (biased < 0)
            relu_out = '0;
        else if (biased > OUT_MAX)
            relu_out = OUT_MAX[DATA_WIDTH-1:0];
        else
            relu_out = biased[DATA_WIDTH-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (window_valid)
            dot_q <= dot;
        if (dot_valid)
        begin
            if (!last_depth)
                psum_buf[pos_cnt] <= psum_total;
            ofm_data <= relu_out;
            ofm_addr <= OFM_ADDR_WIDTH'(filter_idx * (OFM_SIZE * OFM_SIZE) + pos_cnt);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            dot_valid  <= 1'b0;
            pos_cnt    <= '0;
            ofm_we     <= 1'b0;
            plane_done <= 1'b0;
        end
        else
        begin
            dot_valid  <= window_valid;
            ofm_we     <= dot_valid && last_depth;
            plane_done <= dot_valid && last_depth && (pos_cnt == OFM_SIZE * OFM_SIZE - 1);
            if (dot_valid)
                pos_cnt <= (pos_cnt == OFM_SIZE * OFM_SIZE - 1) ? '0 : pos_cnt + 1'b1;
        end
    end

    // writes only come out of the final channel.
    assert property (@(posedge clk) disable iff (reset) ofm_we |-> last_depth);

endmodule

/* rtl/conv_layer_top.sv */
`timescale 1ns/100ps

module conv_layer_top
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   start,
    output logic                                   ready,
    output logic                                   done,
    output logic                                   ifm_rd,
    output logic [conv_pkg::IFM_ADDR_WIDTH-1:0]    ifm_addr,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] ifm_data,
    output logic                                   wt_rd,
    output logic [conv_pkg::WT_ADDR_WIDTH-1:0]     wt_addr,
    input  logic signed [conv_pkg::DATA_WIDTH-1:0] wt_data,
    output logic                                   ofm_we,
    output logic [conv_pkg::OFM_ADDR_WIDTH-1:0]    ofm_addr,
    output logic signed [conv_pkg::DATA_WIDTH-1:0] ofm_data,
    output logic                                   plane_full,
    input  logic                                   plane_ack
);
    import conv_pkg::*;

    logic                         load_go;
    logic                         kernel_ready;
    logic [FILTER_IDX_WIDTH-1:0]  filter_idx;
    logic [DEPTH_IDX_WIDTH-1:0]   depth_idx;
    logic                         first_depth;
    logic                         last_depth;
    logic                         pix_valid;
    logic                         window_valid;
    logic                         plane_done;
    logic signed [DATA_WIDTH-1:0] window [KERNEL_TAPS];
    logic signed [DATA_WIDTH-1:0] kernel [KERNEL_TAPS];
    logic signed [DATA_WIDTH-1:0] bias;

    conv_control u_control (
        .clk(clk), .reset(reset), .start(start), .kernel_ready(kernel_ready),
        .plane_done(plane_done), .plane_ack(plane_ack), .ready(ready), .done(done),
        .plane_full(plane_full), .ifm_rd(ifm_rd), .ifm_addr(ifm_addr),
        .pix_valid(pix_valid), .load_go(load_go), .filter_idx(filter_idx),
        .depth_idx(depth_idx), .first_depth(first_depth), .last_depth(last_depth)
    );

    window_shifter u_window (
        .clk(clk), .reset(reset), .pix_valid(pix_valid), .ifm_data(ifm_data),
        .window(window), .window_valid(window_valid)
    );

    weight_fetch u_weights (
        .clk(clk), .reset(reset), .load_go(load_go), .filter_idx(filter_idx),
        .depth_idx(depth_idx), .wt_data(wt_data), .wt_rd(wt_rd), .wt_addr(wt_addr),
        .kernel(kernel), .bias(bias), .kernel_ready(kernel_ready)
    );

    mac_accumulate u_mac (
        .clk(clk), .reset(reset), .window(window), .window_valid(window_valid),
        .kernel(kernel), .bias(bias), .first_depth(first_depth),
        .last_depth(last_depth), .filter_idx(filter_idx), .ofm_we(ofm_we),
        .ofm_addr(ofm_addr), .ofm_data(ofm_data), .plane_done(plane_done)
    );

endmodule

/* sim/conv_layer_tb.sv */
`timescale 1ns/100ps

module conv_layer_tb;
    import conv_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int NUM_RUNS      = 3;
    localparam int MAX_ACK_DELAY = 20;
    localparam int IFM_WORDS     = IFM_DEPTH * IFM_SIZE * IFM_SIZE;
    localparam int WT_WORDS      = BIAS_BASE + NUM_FILTERS;
    localparam int OFM_WORDS     = NUM_FILTERS * OFM_SIZE * OFM_SIZE;
    // load, stream and drain per channel, then the worst acknowledge wait per plane.
    localparam int RUN_CYCLES = NUM_FILTERS * (IFM_DEPTH * (KERNEL_TAPS + 4 + IFM_SIZE * IFM_SIZE
                                + DRAIN_CYCLES) + MAX_ACK_DELAY + 4) + 8;
    localparam int TIMEOUT_NS = 3 * (NUM_RUNS * RUN_CYCLES + 8) * CLK_PERIOD;

    logic                         clk;
    logic                         reset;
    logic                         start;
    logic                         ready;
    logic                         done;
    logic                         ifm_rd;
    logic [IFM_ADDR_WIDTH-1:0]    ifm_addr;
    logic signed [DATA_WIDTH-1:0] ifm_data;
    logic                         wt_rd;
    logic [WT_ADDR_WIDTH-1:0]     wt_addr;
    logic signed [DATA_WIDTH-1:0] wt_data;
    logic                         ofm_we;
    logic [OFM_ADDR_WIDTH-1:0]    ofm_addr;
    logic signed [DATA_WIDTH-1:0] ofm_data;
    logic                         plane_full;
    logic                         plane_ack;

    logic signed [DATA_WIDTH-1:0] ifm_mem [IFM_WORDS];
    logic signed [DATA_WIDTH-1:0] wt_mem [WT_WORDS];
    logic signed [DATA_WIDTH-1:0] expected [OFM_WORDS];
    logic signed [DATA_WIDTH-1:0] exp_data;
    logic                         ifm_rd_q = 1'b0;
    logic [IFM_ADDR_WIDTH-1:0]    ifm_addr_q = '0;
    logic                         wt_rd_q = 1'b0;
    logic [WT_ADDR_WIDTH-1:0]     wt_addr_q = '0;

    int errors = 0;
    int words = 0;
    int wr_count = 0;
    int done_count = 0;
    int burst_len = 0;
    int wt_reads = 0;

    conv_layer_top dut (
        .clk(clk), .reset(reset), .start(start), .ready(ready), .done(done),
        .ifm_rd(ifm_rd), .ifm_addr(ifm_addr), .ifm_data(ifm_data),
        .wt_rd(wt_rd), .wt_addr(wt_addr), .wt_data(wt_data),
        .ofm_we(ofm_we), .ofm_addr(ofm_addr), .ofm_data(ofm_data),
        .plane_full(plane_full), .plane_ack(plane_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one cycle read latency, address taken on one falling edge, data on the next.
    always @(negedge clk)
    begin
        if (ifm_rd_q)
            ifm_data = ifm_mem[ifm_addr_q];
        if (wt_rd_q)
            wt_data = wt_mem[wt_addr_q];
        ifm_rd_q   = ifm_rd;
        ifm_addr_q = ifm_addr;
        wt_rd_q    = wt_rd;
        wt_addr_q  = wt_addr;
    end

    assign exp_data = expected[ofm_addr];

    always @(posedge clk)
    begin
        if (start && ready)
        begin
            wr_count   <= 0;
            done_count <= 0;
            wt_reads   <= 0;
        end
        else
        begin
            if (ofm_we)
                wr_count <= wr_count + 1;
            if (done)
                done_count <= done_count + 1;
            if (wt_rd)
                wt_reads <= wt_reads + 1;
        end
        if (ofm_we)
            words <= words + 1;
        burst_len <= ifm_rd ? burst_len + 1 : 0; // length of the current read burst.
    end

    task automatic report_mismatch(input string name, input longint exp_val,
                                   input longint act_val);
        errors++;
        $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp_val, act_val);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // kernels are fetched in storage order, nine taps then the filter bias.
    function automatic int expected_wt_addr(input int n);
        int fetch_num;
        int word_num;
        fetch_num = n / (KERNEL_TAPS + 1);
        word_num  = n % (KERNEL_TAPS + 1);
        if (word_num < KERNEL_TAPS)
            return fetch_num * KERNEL_TAPS + word_num;
        else
            return BIAS_BASE + fetch_num / IFM_DEPTH;
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < IFM_WORDS; i++)
            ifm_mem[i] = DATA_WIDTH'(int'($urandom % 41) - 20);
        for (int i = 0; i < WT_WORDS; i++)
        begin
            if ($urandom % 8 == 0)
                wt_mem[i] = DATA_WIDTH'(2000 + int'($urandom % 2000)); // drives the clamp.
            else
                wt_mem[i] = DATA_WIDTH'(int'($urandom % 21) - 10);
        end
    endtask

    // relu of bias plus all taps over depth, saturated to 16 bits.
    task automatic build_reference();
        longint acc;
        for (int f = 0; f < NUM_FILTERS; f++)
            for (int r = 0; r < OFM_SIZE; r++)
                for (int c = 0; c < OFM_SIZE; c++)
                begin
                    acc = wt_mem[BIAS_BASE + f];
                    for (int d = 0; d < IFM_DEPTH; d++)
                        for (int kr = 0; kr < KERNEL_SIZE; kr++)
                            for (int kc = 0; kc < KERNEL_SIZE; kc++)
                                acc += longint'(ifm_mem[d * IFM_SIZE * IFM_SIZE
                                       + (r + kr) * IFM_SIZE + c + kc])
                                     * longint'(wt_mem[(f * IFM_DEPTH + d) * KERNEL_TAPS
                                       + kr * KERNEL_SIZE + kc]);
                    if (acc < 0)
                        acc = 0;
                    else if (acc > 32767)
                        acc = 32767;
                    expected[f * OFM_SIZE * OFM_SIZE + r * OFM_SIZE + c] = DATA_WIDTH'(acc);
                end
    endtask

    task automatic run_layer();
        fill_memories();
        build_reference();
        @(negedge clk);
        while (!ready)
            @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!ifm_rd)
            @(negedge clk);
        repeat (5) @(negedge clk);
        start = 1'b1; // must be ignored mid stream.
        @(negedge clk);
        start = 1'b0;
        while (!done)
            @(negedge clk);
        @(negedge clk);
    endtask

    // next layer takes each plane after a random delay.
    initial
    begin
        int delay;
        plane_ack = 1'b0;
        forever
        begin
            @(negedge clk);
            if (plane_full && !plane_ack)
            begin
                delay = int'($urandom % (MAX_ACK_DELAY + 1));
                repeat (delay) @(negedge clk);
                plane_ack = 1'b1;
                @(negedge clk);
                plane_ack = 1'b0;
            end
        end
    end

    initial
    begin
        void'($urandom(48895));
        reset    = 1'b1;
        start    = 1'b0;
        ifm_data = '0;
        wt_data  = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        for (int run = 0; run < NUM_RUNS; run++)
            run_layer();
        repeat (4) @(negedge clk);
        $display("%0d output words checked, %0d errors", words, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: layer runs did not complete in time");
        $display("%0d output words checked, %0d errors", words, errors + 1);
        $display("Errors found");
        $finish;
    end

    assert property (@(posedge clk) disable iff (reset) ofm_we |-> ofm_data == exp_data)
    else report_mismatch("ofm_data", $sampled(exp_data), $sampled(ofm_data));

    assert property (@(posedge clk) disable iff (reset) ofm_we |-> int'(ofm_addr) == wr_count)
    else report_mismatch("ofm_addr", $sampled(wr_count), $sampled(ofm_addr));

    assert property (@(posedge clk) disable iff (reset)
        wt_rd |-> int'(wt_addr) == expected_wt_addr(wt_reads))
    else report_mismatch("wt_addr", expected_wt_addr($sampled(wt_reads)), $sampled(wt_addr));

    assert property (@(posedge clk) disable iff (reset)
        $rose(plane_full) |-> wr_count != 0 && wr_count % (OFM_SIZE * OFM_SIZE) == 0)
    else report_failure("plane_full rose without a complete 16 word plane");

    assert property (@(posedge clk) disable iff (reset) plane_full |-> !ifm_rd && !ofm_we)
    else report_failure("memory access while plane_full was high");

    assert property (@(posedge clk) disable iff (reset) $fell(plane_full) |-> $past(plane_ack))
    else report_failure("plane_full fell without an acknowledge");

    assert property (@(posedge clk) disable iff (reset) start && ready |=> !ready)
    else report_failure("ready stayed high after an accepted start");

    assert property (@(posedge clk) disable iff (reset) start && !ready && !plane_full |=> !ready)
    else report_failure("start while busy was not ignored");

    assert property (@(posedge clk) disable iff (reset) done |-> done_count == 0)
    else report_failure("done pulsed more than once in a run");

    assert property (@(posedge clk) disable iff (reset) done |-> wr_count == OFM_WORDS)
    else report_mismatch("write count", OFM_WORDS, $sampled(wr_count));

    assert property (@(posedge clk) disable iff (reset)
        done |-> $past(plane_ack) && $past(plane_full) && ready)
    else report_failure("done not right after the last plane acknowledge with ready high");

    assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else report_failure("done longer than one cycle");

    assert property (@(posedge clk)
        $fell(reset) |-> ready && !ifm_rd && !wt_rd && !ofm_we && !plane_full && !done)
    else report_failure("outputs not in idle state right after reset");

    assert property (@(posedge clk) disable iff (reset) $fell(ifm_rd) |-> burst_len == 36)
    else report_mismatch("ifm_rd burst length", 36, $sampled(burst_len));

    assert property (@(posedge clk) disable iff (reset)
        $rose(ifm_rd) |-> ifm_addr % (IFM_SIZE * IFM_SIZE) == 0)
    else report_failure("ifm_rd burst did not start at a channel base");

    assert property (@(posedge clk) disable iff (reset)
        ifm_rd && $past(ifm_rd) |-> ifm_addr == $past(ifm_addr) + 1)
    else report_mismatch("ifm_addr", $past(ifm_addr) + 1, $sampled(ifm_addr));

endmodule

/* conv_layer.f */
rtl/conv_pkg.sv
rtl/conv_control.sv
rtl/window_shifter.sv
rtl/weight_fetch.sv
rtl/mac_accumulate.sv
rtl/conv_layer_top.sv
sim/conv_layer_tb.sv
